// ==== aes_dec.f ====
+incdir+test
rtl/aes_dec_pkg.sv
rtl/aes_inv_round.sv
rtl/aes_round_key_store.sv
rtl/aes_dec_regs.sv
rtl/aes_dec_engine.sv
rtl/aes_dec_top.sv
test/tb_aes_dec.sv

// ==== Bender.yml ====
package:
  name: aes_dec

sources:
  - rtl/aes_dec_pkg.sv
  - rtl/aes_inv_round.sv
  - rtl/aes_round_key_store.sv
  - rtl/aes_dec_regs.sv
  - rtl/aes_dec_engine.sv
  - rtl/aes_dec_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_aes_dec.sv

// ==== test/aes_enc_ref.svh ====
`ifndef AES_ENC_REF_SVH
`define AES_ENC_REF_SVH

localparam byte_t fwd_sbox [0:255] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
};

function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
endfunction

// multiplies one column by the fixed matrix 2 3 1 1.
function automatic word_t mix_column(input word_t col);
    byte_t a0;
    byte_t a1;
    byte_t a2;
    byte_t a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
endfunction

// forward cipher over key_sched, key 0 first and key num_rounds last.
function automatic state_t aes_encrypt(input state_t pt);
    state_t s;
    state_t t;
    s = pt ^ key_sched[0];
    for (int rnd = 1; rnd <= num_rounds; rnd++)
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                t[127 - 32 * c - 8 * r -: 8] =
                    fwd_sbox[s[127 - 32 * ((c + r) % 4) - 8 * r -: 8]]; // row r moves left by r.
            end
        end
        for (int c = 0; c < 4; c++)
        begin
            s[127 - 32 * c -: 32] = (rnd < num_rounds) ? mix_column(t[127 - 32 * c -: 32])
                                                         : t[127 - 32 * c -: 32];
        end
        s = s ^ key_sched[rnd];
    end
    return s;
endfunction

// right shifting Galois LFSR, taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

`endif

// ==== test/tb_aes_dec.sv ====
`default_nettype none

module tb_aes_dec
    import aes_dec_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_rounds = 10;
    localparam int num_blocks = 20;
    localparam int busy_block = 3; // this block also tries writes while the engine runs.
    localparam int words_per_block = 4 * (num_rounds + 1) + 4 + 1 + 4 + 2;
    localparam int cycles_per_block = 2 * words_per_block + 2 * num_rounds + 20;
    localparam int max_cycles = cycles_per_block * (num_blocks + 1) + 200;

    logic      clk;
    logic      reset;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    state_t      key_sched [0:num_rounds];
    logic [31:0] lfsr = 32'd73;
    int          mismatch_count = 0;
    int          failure_count = 0;
    int          cycle_count = 0;
    state_t      exp_q [$];
    state_t      got_q [$];

`include "aes_enc_ref.svh"

    aes_dec_top #(
        .num_rounds (num_rounds)
    ) i_aes_dec_top (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    task automatic print_counts();
        $display("Summary: %0d mismatches, %0d other failures.", mismatch_count, failure_count);
    endtask

    initial
    begin
        while (cycle_count < max_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the test did not finish.", cycle_count);
        print_counts();
        $display("ERRORS FOUND");
        $finish;
    end

    // compares each plaintext read back with the one chosen before encryption.
    initial
    begin
        state_t got;
        state_t exp;
        forever
        begin
            @(negedge clk);
            while (got_q.size() > 0)
            begin
                got = got_q.pop_front();
                exp = exp_q.pop_front();
                if (got !== exp)
                begin
                    $display("Mismatch at %0t: plaintext got %h expected %h", $time, got, exp);
                    mismatch_count++;
                end
            end
        end
    end

    task automatic rand_word(output word_t w);
        for (int i = 0; i < 32; i++)
        begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_state(output state_t s);
        word_t w;
        for (int i = 0; i < 4; i++)
        begin
            rand_word(w);
            s[127 - 32 * i -: 32] = w;
        end
    endtask

    // each access starts 10 ns after an edge and returns 10 ns after the edge that ends it.
    task automatic apb_access(input apb_addr_t addr, input logic wr, input word_t wdata,
                              input logic exp_err, output word_t rdata);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #10;
        penable = 1'b1;
        #40;
        rdata = prdata; // middle of the access phase.
        if (pready !== 1'b1)
        begin
            $display("Mismatch at %0t: pready got %b expected 1 (address %h)",
                     $time, pready, addr);
            mismatch_count++;
        end
        if (pslverr !== exp_err)
        begin
            $display("Mismatch at %0t: pslverr got %b expected %b (address %h)",
                     $time, pslverr, exp_err, addr);
            mismatch_count++;
        end
        @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input word_t data, input logic exp_err);
        word_t unused;
        apb_access(addr, 1'b1, data, exp_err, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output word_t data, input logic exp_err);
        apb_access(addr, 1'b0, 32'd0, exp_err, data);
    endtask

    task automatic check_status(input logic exp_busy, input logic exp_done);
        word_t v;
        apb_read(status_addr, v, 1'b0);
        if (v[0] !== exp_busy)
        begin
            $display("Mismatch at %0t: busy got %b expected %b", $time, v[0], exp_busy);
            mismatch_count++;
        end
        if (v[1] !== exp_done)
        begin
            $display("Mismatch at %0t: done got %b expected %b", $time, v[1], exp_done);
            mismatch_count++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic wait_done();
        word_t v;
        int    polls;
        polls = 0;
        v = '0;
        while (v[1] !== 1'b1 && polls < 4 * num_rounds)
        begin
            apb_read(status_addr, v, 1'b0);
            polls++;
        end
        if (v[1] !== 1'b1)
        begin
            $display("At %0t the done flag was never set after start.", $time);
            failure_count++;
        end
    endtask

    task automatic load_keys();
        for (int r = 0; r <= num_rounds; r++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                apb_write(apb_addr_t'(key_base + 16 * r + 4 * k),
                          key_sched[r][127 - 32 * k -: 32], 1'b0);
            end
        end
    endtask

    task automatic load_ciphertext(input state_t ct);
        for (int w = 0; w < 4; w++)
        begin
            apb_write(apb_addr_t'(data_in_base + 4 * w), ct[127 - 32 * w -: 32], 1'b0);
        end
    endtask

    task automatic read_plaintext(output state_t pt);
        word_t v;
        for (int w = 0; w < 4; w++)
        begin
            apb_read(apb_addr_t'(data_out_base + 4 * w), v, 1'b0);
            pt[127 - 32 * w -: 32] = v;
        end
    endtask

    // the start edge ends the control write, the first status access phase follows it.
    // done must show in the access phase that begins num_rounds edges after the start edge.
    task automatic start_and_time(input int blk);
        apb_write(ctrl_addr, 32'd1, 1'b0);
        check_status(1'b1, 1'b0);
        if (blk == busy_block)
        begin
            apb_write(key_base, 32'hdead_beef, 1'b1);
            apb_write(data_in_base, 32'h0bad_cafe, 1'b1);
            apb_write(ctrl_addr, 32'd1, 1'b1);
        end
        else if (blk % 2 == 0)
        begin
            wait_cycles(num_rounds - 4);
            check_status(1'b1, 1'b0);
        end
        else
        begin
            wait_cycles(num_rounds - 3);
            check_status(1'b0, 1'b1);
        end
        wait_done();
    endtask

    initial
    begin
        state_t pt;
        state_t ct;
        state_t got;
        word_t  v;
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;

        check_status(1'b0, 1'b0);
        apb_read(data_in_base, v, 1'b0);
        apb_read(data_out_base, v, 1'b0);

        for (int blk = 0; blk < num_blocks; blk++)
        begin
            for (int r = 0; r <= num_rounds; r++)
            begin
                rand_state(key_sched[r]);
            end
            rand_state(pt);
            ct = aes_encrypt(pt);
            load_keys();
            load_ciphertext(ct);
            start_and_time(blk);
            read_plaintext(got);
            exp_q.push_back(pt);
            got_q.push_back(got);
        end

        // illegal accesses, none of which may disturb the loaded block.
        apb_read(12'h200, v, 1'b1);
        apb_write(apb_addr_t'(key_base + 16 * (num_rounds + 1)), 32'h1234_5678, 1'b1);
        apb_write(12'h1f0, 32'h1234_5678, 1'b1);
        apb_write(status_addr, 32'h3, 1'b1);
        apb_write(apb_addr_t'(data_out_base + 4), 32'hffff_ffff, 1'b1);
        check_status(1'b0, 1'b1);
        apb_write(ctrl_addr, 32'd1, 1'b0);
        wait_done();
        read_plaintext(got);
        exp_q.push_back(pt);
        got_q.push_back(got);

        repeat (2) @(posedge clk);
        print_counts();
        if (mismatch_count + failure_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/aes_dec_top.sv ====
`default_nettype none

module aes_dec_top
    import aes_dec_pkg::*;
#(
    parameter int num_rounds = 10 // 10, 12 or 14 for the three key sizes.
)
(
    input  logic      clk,
    input  logic      reset,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr
);
    logic       key_we;
    logic [5:0] key_addr;
    word_t      key_wdata;
    logic       start;
    logic       busy;
    logic       done_pulse;
    state_t     ciphertext;
    state_t     plaintext;
    state_t     round_key;
    round_idx_t round_sel;

    aes_dec_regs #(
        .num_rounds (num_rounds)
    ) i_aes_dec_regs (
        .clk        (clk),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .done_pulse (done_pulse),
        .plaintext  (plaintext),
        .key_we     (key_we),
        .key_addr   (key_addr),
        .key_wdata  (key_wdata),
        .start      (start),
        .ciphertext (ciphertext)
    );

    aes_round_key_store #(
        .num_rounds (num_rounds)
    ) i_aes_round_key_store (
        .clk       (clk),
        .key_we    (key_we),
        .key_addr  (key_addr),
        .key_wdata (key_wdata),
        .round_sel (round_sel),
        .round_key (round_key)
    );

    aes_dec_engine #(
        .num_rounds (num_rounds)
    ) i_aes_dec_engine (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .ciphertext (ciphertext),
        .round_key  (round_key),
        .round_sel  (round_sel),
        .busy       (busy),
        .done_pulse (done_pulse),
        .plaintext  (plaintext)
    );

endmodule

`default_nettype wire

// ==== rtl/aes_dec_engine.sv ====
`default_nettype none

module aes_dec_engine
    import aes_dec_pkg::*;
#(
    parameter int num_rounds = 10
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  state_t     ciphertext,
    input  state_t     round_key,
    output round_idx_t round_sel,
    output logic       busy,
    output logic       done_pulse,
    output state_t     plaintext
);
    typedef enum logic [1:0] {idle, first, round} engine_state_t;

    localparam round_idx_t top_round = round_idx_t'(num_rounds);

    engine_state_t fsm;
    round_idx_t    round_cnt;
    state_t        state_q;
    state_t        round_out;
    logic          last;

    // while idle the counter rests on the top key, which the initial AddRoundKey needs.
    assign round_sel  = round_cnt;
    assign last       = (round_cnt == '0);
    assign busy       = (fsm != idle);
    assign done_pulse = busy && last;
    assign plaintext  = round_out; // captured by the register module on done_pulse.

    aes_inv_round i_aes_inv_round (
        .state_in  (state_q),
        .round_key (round_key),
        .last      (last),
        .state_out (round_out)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fsm       <= idle;
            round_cnt <= top_round;
        end
        else
        begin
            case (fsm)
                idle:
                begin
                    if (start)
                    begin
                        fsm       <= first;
                        round_cnt <= top_round - 1'b1;
                    end
                end
                first, round:
                begin
                    if (last)
                    begin
                        fsm       <= idle;
                        round_cnt <= top_round;
                    end
                    else
                    begin
                        fsm       <= round;
                        round_cnt <= round_cnt - 1'b1;
                    end
                end
                default:
                begin
                    fsm       <= idle;
                    round_cnt <= top_round;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fsm == idle && start)
        begin
            state_q <= ciphertext ^ round_key;
        end
        else if (busy)
        begin
            state_q <= round_out;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/aes_dec_regs.sv ====
`default_nettype none

module aes_dec_regs
    import aes_dec_pkg::*;
#(
    parameter int num_rounds = 10
)
(
    input  logic       clk,
    input  logic       reset,
    input  apb_addr_t  paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    input  logic       busy,
    input  logic       done_pulse,
    input  state_t     plaintext,
    output logic       key_we,
    output logic [5:0] key_addr,
    output word_t      key_wdata,
    output logic       start,
    output state_t     ciphertext
);
    localparam apb_addr_t key_end = apb_addr_t'(key_base + 16 * (num_rounds + 1));

    logic       access;
    logic       key_hit;
    logic       din_hit;
    logic       ctrl_hit;
    logic       stat_hit;
    logic       dout_hit;
    logic       err;
    logic       wr_ok;
    logic [1:0] word_sel;
    logic       done;
    state_t     plaintext_q;

    assign access   = psel && penable;
    assign word_sel = paddr[3:2]; // word 0 is the top word of the state.

    // the two low address bits are ignored, all registers are word wide.
    assign key_hit  = (paddr >= key_base) && (paddr < key_end);
    assign din_hit  = (paddr[11:4] == data_in_base[11:4]);
    assign ctrl_hit = (paddr[11:2] == ctrl_addr[11:2]);
    assign stat_hit = (paddr[11:2] == status_addr[11:2]);
    assign dout_hit = (paddr[11:4] == data_out_base[11:4]);

    assign err = access && (!(key_hit || din_hit || ctrl_hit || stat_hit || dout_hit)
                 || (pwrite && busy && (key_hit || din_hit || ctrl_hit))
                 || (pwrite && (stat_hit || dout_hit)));

    assign wr_ok   = access && pwrite && !err;
    assign pready  = 1'b1; // zero wait states.
    assign pslverr = err;

    assign key_we    = wr_ok && key_hit;
    assign key_addr  = paddr[7:2];
    assign key_wdata = pwdata;
    assign start     = wr_ok && ctrl_hit && pwdata[0];

    always_ff @(posedge clk)
    begin
        if (wr_ok && din_hit)
        begin
            ciphertext[127 - 32 * word_sel -: 32] <= pwdata;
        end
        if (done_pulse)
        begin
            plaintext_q <= plaintext;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done <= 1'b0;
        end
        else if (start)
        begin
            done <= 1'b0;
        end
        else if (done_pulse)
        begin
            done <= 1'b1;
        end
    end

    always_comb
    begin
        prdata = '0; // keys and control read back as zero.
        if (stat_hit)
        begin
            prdata = {30'd0, done, busy};
        end
        else if (din_hit)
        begin
            prdata = ciphertext[127 - 32 * word_sel -: 32];
        end
        else if (dout_hit)
        begin
            prdata = plaintext_q[127 - 32 * word_sel -: 32];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/aes_round_key_store.sv ====
`default_nettype none

module aes_round_key_store
    import aes_dec_pkg::*;
#(
    parameter int num_rounds = 10
)
(
    input  logic       clk,
    input  logic       key_we,
    input  logic [5:0] key_addr,
    input  word_t      key_wdata,
    input  round_idx_t round_sel,
    output state_t     round_key
);
    localparam int num_words = 4 * (num_rounds + 1);

    word_t mem [num_words];

    // the register module only passes addresses inside the key range.
    always_ff @(posedge clk)
    begin
        if (key_we)
        begin
            mem[key_addr] <= key_wdata;
        end
    end

    // four words of one key, top word first.
    assign round_key = {
        mem[{round_sel, 2'd0}],
        mem[{round_sel, 2'd1}],
        mem[{round_sel, 2'd2}],
        mem[{round_sel, 2'd3}]
    };

endmodule

`default_nettype wire

// ==== rtl/aes_inv_round.sv ====
`default_nettype none

module aes_inv_round
    import aes_dec_pkg::*;
(
    input  state_t state_in,
    input  state_t round_key,
    input  logic   last,
    output state_t state_out
);
    state_t sub_state;
    state_t keyed;
    state_t mixed;

    // byte r of column c sits at bit 127 - 32c - 8r.
    // Row r rotates right by r columns, and the S-box is bytewise so both steps merge.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                sub_state[127 - 32 * c - 8 * r -: 8] =
                    inv_sbox[state_in[127 - 32 * ((c + 4 - r) % 4) - 8 * r -: 8]];
            end
        end
    end

    assign keyed = sub_state ^ round_key;

    // each output byte takes 14, 11, 13, 9 times the column bytes from its own row down.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                mixed[127 - 32 * c - 8 * r -: 8] =
                    gf_mul(keyed[127 - 32 * c - 8 * r -: 8], 4'd14) ^
                    gf_mul(keyed[127 - 32 * c - 8 * ((r + 1) % 4) -: 8], 4'd11) ^
                    gf_mul(keyed[127 - 32 * c - 8 * ((r + 2) % 4) -: 8], 4'd13) ^
                    gf_mul(keyed[127 - 32 * c - 8 * ((r + 3) % 4) -: 8], 4'd9);
            end
        end
    end

    assign state_out = last ? keyed : mixed; // the final round has no InvMixColumns.

endmodule

`default_nettype wire

// ==== rtl/aes_dec_pkg.sv ====
`default_nettype none

package aes_dec_pkg;

    typedef logic [127:0] state_t;
    typedef logic [31:0]  word_t;
    typedef logic [7:0]   byte_t;
    typedef logic [11:0]  apb_addr_t;
    typedef logic [3:0]   round_idx_t;

    // byte offsets of the APB register map.
    localparam apb_addr_t key_base      = 12'h000;
    localparam apb_addr_t data_in_base  = 12'h100;
    localparam apb_addr_t ctrl_addr     = 12'h110;
    localparam apb_addr_t status_addr   = 12'h114;
    localparam apb_addr_t data_out_base = 12'h120;

    localparam byte_t gf_poly = 8'h1b; // x^8 + x^4 + x^3 + x + 1 without the top bit.

    localparam byte_t inv_sbox [0:255] = '{
        8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
        8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
        8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
        8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
        8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
        8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
        8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
        8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
        8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
        8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
        8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
        8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
        8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
        8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
        8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
        8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
        8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
        8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
        8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
        8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
        8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
        8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
        8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
        8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
        8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
        8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
        8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
        8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
        8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
        8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
        8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
        8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
    };

    function automatic byte_t gf_mul2(input byte_t b);
        return {b[6:0], 1'b0} ^ (gf_poly & {8{b[7]}});
    endfunction

    // shift and add over the four bits of the constant, enough for 9, 11, 13 and 14.
    function automatic byte_t gf_mul(input byte_t b, input logic [3:0] c);
        byte_t acc;
        byte_t pow;
        acc = '0;
        pow = b;
        for (int i = 0; i < 4; i++)
        begin
            if (c[i])
            begin
                acc = acc ^ pow;
            end
            pow = gf_mul2(pow);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire
